// File: hw/ravr_pkg.sv
/*
 * shared definitions of the reduced AVR core
 * ALU command codes, opcode groups, flash fetch phases,
 * flag and decoded-instruction structs
 */
package ravr_pkg;

	// instruction pointer width, 512 words of user flash
	localparam int PC_W = 9;

	// fetch phase counter
	localparam int PHASE_W = 6;
	// address shifts while phase is below this
	localparam logic [PHASE_W-1:0] PHASE_ADDR_END = 6'd9;
	// result write back, also first data shift
	localparam logic [PHASE_W-1:0] PHASE_FIX = 6'd10;
	// pointer and flash address increment
	localparam logic [PHASE_W-1:0] PHASE_INC = 6'd15;
	// all 16 opcode bits in
	localparam logic [PHASE_W-1:0] PHASE_READY = 6'd26;

	// upper nibble of the immediate and branch encodings
	localparam logic [3:0] OP_CPI = 4'h3;
	localparam logic [3:0] OP_SUBI = 4'h5;
	localparam logic [3:0] OP_ORI = 4'h6;
	localparam logic [3:0] OP_ANDI = 4'h7;
	localparam logic [3:0] OP_LDI = 4'hE;
	localparam logic [3:0] OP_BRANCH = 4'hF;

	// numbering follows the reg-reg encoding {op[13], op[11:10]}
	typedef enum logic [2:0] {
		CMD_LSR = 3'd0,
		CMD_CP  = 3'd1,
		CMD_SUB = 3'd2,
		CMD_ADD = 3'd3,
		CMD_AND = 3'd4,
		CMD_EOR = 3'd5,
		CMD_OR  = 3'd6,
		CMD_MOV = 3'd7
	} alu_cmd_t;

	typedef struct packed {
		logic z;
		logic c;
	} flags_t;

	typedef struct packed {
		alu_cmd_t        cmd;
		logic            use_imm;
		logic [7:0]      imm;
		logic [2:0]      dest_idx;
		logic [2:0]      src_idx;
		logic            writes_dest;
		logic            writes_flags;
		logic            take_branch;
		logic [PC_W-1:0] offset;
	} decoded_t;

endpackage

// File: hw/ufm_sequencer.sv
/*
 * serial user flash fetch sequencer
 * phase counter, instruction pointer, opcode shift register,
 * flash address/data strobes and internal phase pulses
 */
module ufm_sequencer
	import ravr_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            take_branch,
	input  logic [PC_W-1:0] offset,
	input  logic            drdin,
	output logic [15:0]     opcode,
	output logic            opcode_ready,
	output logic            fix_result,
	output logic            arclkena,
	output logic            arclkshift,
	output logic            ardout,
	output logic            drshift
);

	logic [PHASE_W-1:0] phase;
	logic [PC_W-1:0] ip;
	logic addr_shift;
	logic addr_inc;
	logic data_shift;

	// phase decode
	assign addr_shift = (phase < PHASE_ADDR_END);
	assign addr_inc = (phase == PHASE_INC);
	assign data_shift = (phase >= PHASE_FIX) && (phase < PHASE_READY);
	assign opcode_ready = (phase == PHASE_READY);
	assign fix_result = (phase == PHASE_FIX);

	// flash pins, held quiet while in reset
	assign arclkshift = addr_shift & ~reset;
	assign arclkena = (addr_shift | addr_inc) & ~reset;
	assign drshift = data_shift & ~reset;
	// address goes out MSB first
	assign ardout = ip[PC_W-1];

	// 17 cycles per instruction, 27 when the address must be reloaded
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			phase <= '0;
		else if (opcode_ready)
		begin
			if (take_branch)
				phase <= '0;
			else
				phase <= PHASE_FIX;
		end
		else
			phase <= phase + PHASE_W'(1);
	end

	// pointer rotates through a full turn while shifting out
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ip <= '0;
		else if (addr_shift)
			ip <= {ip[PC_W-2:0], ip[PC_W-1]};
		else if (addr_inc)
			ip <= ip + PC_W'(1);
		// relative to the already incremented pointer
		else if (opcode_ready && take_branch)
			ip <= ip + offset;
	end

	// opcode bits arrive MSB first
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			opcode <= '0;
		else if (data_shift)
			opcode <= {opcode[14:0], drdin};
	end

endmodule

// File: hw/ravr_decode.sv
/*
 * instruction decoder
 * folds reg-reg, immediate, LSR and branch encodings into one
 * ALU command and evaluates the branch condition
 */
module ravr_decode
	import ravr_pkg::*;
(
	input  logic [15:0] opcode,
	input  flags_t      flags,
	output decoded_t    dec
);

	logic is_branch;
	logic cond_met;
	logic [1:0] branch_id;

	assign is_branch = (opcode[15:12] == OP_BRANCH);
	// {op[10], op[0]}: 01 BREQ, 11 BRNE, 00 BRCS, 10 BRCC
	assign branch_id = {opcode[10], opcode[0]};

	always_comb
	begin
		case (branch_id)
			2'b01: cond_met = flags.z;
			2'b11: cond_met = ~flags.z;
			2'b00: cond_met = flags.c;
			default: cond_met = ~flags.c;
		endcase
	end

	always_comb
	begin
		dec = '0;
		dec.imm = {opcode[11:8], opcode[3:0]};
		dec.dest_idx = opcode[6:4];
		dec.src_idx = opcode[2:0];
		// 7-bit displacement in words, sign extended
		dec.offset = {{2{opcode[9]}}, opcode[9:3]};

		if ((opcode[15:14] == 2'b00) && (opcode[13:12] != 2'b11))
			dec.cmd = alu_cmd_t'({opcode[13], opcode[11:10]});
		else if (opcode[15:14] == 2'b10)
			dec.cmd = CMD_LSR;
		else
		begin
			dec.use_imm = 1'b1;
			case (opcode[15:12])
				OP_SUBI: dec.cmd = CMD_SUB;
				OP_ANDI: dec.cmd = CMD_AND;
				OP_ORI:  dec.cmd = CMD_OR;
				OP_LDI:  dec.cmd = CMD_MOV;
				// CPI and branches
				default: dec.cmd = CMD_CP;
			endcase
		end

		dec.writes_dest = ~is_branch && (dec.cmd != CMD_CP);
		dec.writes_flags = ~is_branch;
		dec.take_branch = is_branch && cond_met;
	end

endmodule

// File: hw/ravr_alu.sv
/*
 * 8-bit ALU
 * operand and command latch, result and next flags
 */
module ravr_alu
	import ravr_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       opcode_ready,
	input  decoded_t   dec,
	input  logic [7:0] dest_val,
	input  logic [7:0] source_val,
	input  flags_t     flags,
	output logic [7:0] result,
	output flags_t     next_flags
);

	logic [7:0] operand0;
	logic [7:0] operand1;
	alu_cmd_t cmd;

	// operands held until the write in the next fetch
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			operand0 <= '0;
			operand1 <= '0;
			cmd <= CMD_LSR;
		end
		else if (opcode_ready)
		begin
			operand0 <= dest_val;
			operand1 <= dec.use_imm ? dec.imm : source_val;
			cmd <= dec.cmd;
		end
	end

	always_comb
	begin
		// logic ops leave C alone
		next_flags.c = flags.c;
		case (cmd)
			CMD_CP, CMD_SUB: {next_flags.c, result} = {1'b0, operand0} - {1'b0, operand1};
			CMD_ADD: {next_flags.c, result} = {1'b0, operand0} + {1'b0, operand1};
			CMD_AND: result = operand0 & operand1;
			CMD_EOR: result = operand0 ^ operand1;
			CMD_OR: result = operand0 | operand1;
			CMD_MOV: result = operand1;
			default:
			begin
				// LSR, bit 0 drops into carry
				result = {1'b0, operand0[7:1]};
				next_flags.c = operand0[0];
			end
		endcase
		// MOV keeps Z as well
		next_flags.z = (cmd == CMD_MOV) ? flags.z : (result == 8'h00);
	end

endmodule

// File: hw/ravr_regs.sv
/*
 * register and flag file
 * four registers, port0/port1, saved flags,
 * source and destination read muxes
 */
module ravr_regs
	import ravr_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       fix_result,
	input  decoded_t   dec,
	input  logic [7:0] result,
	input  flags_t     next_flags,
	input  logic [7:0] port2,
	output logic [7:0] dest_val,
	output logic [7:0] source_val,
	output flags_t     flags,
	output logic [7:0] port0,
	output logic [7:0] port1
);

	logic [3:0][7:0] regs;

	// index map: 0..3 regs, 4 port0, 5 port1, 6/7 port2
	function automatic logic [7:0] read_idx(input logic [2:0] idx);
		logic [7:0] val;
		case (idx)
			3'd4: val = port0;
			3'd5: val = port1;
			3'd6, 3'd7: val = port2;
			default: val = regs[idx[1:0]];
		endcase
		return val;
	endfunction

	assign dest_val = read_idx(dec.dest_idx);
	assign source_val = read_idx(dec.src_idx);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			regs <= '0;
			port0 <= '0;
			port1 <= '0;
			flags <= '0;
		end
		else if (fix_result)
		begin
			if (dec.writes_dest)
			begin
				// port2 is input only, writes there are dropped
				case (dec.dest_idx)
					3'd0, 3'd1, 3'd2, 3'd3: regs[dec.dest_idx[1:0]] <= result;
					3'd4: port0 <= result;
					3'd5: port1 <= result;
					default: ;
				endcase
			end
			if (dec.writes_flags)
				flags <= next_flags;
		end
	end

endmodule

// File: hw/ravr_top.sv
/*
 * reduced AVR core top level
 * serial flash pins, three 8-bit ports
 */
module ravr_top
	import ravr_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	output logic       arclkena,
	output logic       arclkshift,
	output logic       ardout,
	input  logic       drdin,
	output logic       drshift,
	output logic [7:0] port0,
	output logic [7:0] port1,
	input  logic [7:0] port2
);

	logic [15:0] opcode;
	logic opcode_ready;
	logic fix_result;
	decoded_t dec;
	flags_t flags;
	flags_t next_flags;
	logic [7:0] dest_val;
	logic [7:0] source_val;
	logic [7:0] result;

	// fetch
	ufm_sequencer i_ufm_sequencer (
		.clk(clk),
		.reset(reset),
		.take_branch(dec.take_branch),
		.offset(dec.offset),
		.drdin(drdin),
		.opcode(opcode),
		.opcode_ready(opcode_ready),
		.fix_result(fix_result),
		.arclkena(arclkena),
		.arclkshift(arclkshift),
		.ardout(ardout),
		.drshift(drshift)
	);

	ravr_decode i_ravr_decode (
		.opcode(opcode),
		.flags(flags),
		.dec(dec)
	);

	// execute, result written back one clock after the latch
	ravr_alu i_ravr_alu (
		.clk(clk),
		.reset(reset),
		.opcode_ready(opcode_ready),
		.dec(dec),
		.dest_val(dest_val),
		.source_val(source_val),
		.flags(flags),
		.result(result),
		.next_flags(next_flags)
	);

	ravr_regs i_ravr_regs (
		.clk(clk),
		.reset(reset),
		.fix_result(fix_result),
		.dec(dec),
		.result(result),
		.next_flags(next_flags),
		.port2(port2),
		.dest_val(dest_val),
		.source_val(source_val),
		.flags(flags),
		.port0(port0),
		.port1(port1)
	);

endmodule

// File: testbench/ufm_model.sv
/*
 * behavioural serial user flash, 512 x 16
 * serial address shift and increment, data reload and shift out
 */
module ufm_model (
	input  logic clk,
	input  logic arclkena,
	input  logic arclkshift,
	input  logic ardout,
	input  logic drshift,
	output logic drdin
);
	timeunit 1ns;
	timeprecision 100ps;

	// program image, filled from the testbench
	logic [15:0] mem [0:511];
	logic [8:0] addr = '0;
	logic [15:0] data = '0;

	// data register MSB is the pin
	assign drdin = data[15];

	always @(posedge clk)
	begin
		// address arrives MSB first
		if (arclkshift)
			addr <= {addr[7:0], ardout};
		// enable alone steps to the next word
		else if (arclkena)
			addr <= addr + 9'd1;

		// reload while idle, shift left while reading
		if (drshift)
			data <= {data[14:0], 1'b0};
		else
			data <= mem[addr];
	end

endmodule

// File: testbench/ravr_chk.sv
/*
 * flash pin assertions for the fetch sequencer
 * strobe combinations and quiet pins in reset
 */
module ravr_chk (
	input logic clk,
	input logic reset,
	input logic arclkena,
	input logic arclkshift,
	input logic ardout,
	input logic drshift
);
	timeunit 1ns;
	timeprecision 100ps;

	// address shift needs the clock enable
	shift_has_ena: assert property (@(posedge clk) arclkshift |-> arclkena)
		else $error("arclkshift high while arclkena low");

	// address and data never move together
	no_shift_overlap: assert property (@(posedge clk) !(drshift && arclkshift))
		else $error("drshift and arclkshift high together");

	// every flash output low in reset
	quiet_in_reset: assert property (@(posedge clk)
		reset |-> !(arclkena || arclkshift || ardout || drshift))
		else $error("flash output active during reset");

endmodule

bind ufm_sequencer ravr_chk i_ravr_chk (
	.clk(clk),
	.reset(reset),
	.arclkena(arclkena),
	.arclkshift(arclkshift),
	.ardout(ardout),
	.drshift(drshift)
);

// File: testbench/ravr_tb.sv
/*
 * testbench for the reduced AVR core
 * clock, reset, watchdog, program builder, directed tests
 */
module ravr_tb
	import ravr_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 6;
	// longest program of any one test, in words
	localparam int MAX_STEPS = 59;
	// 27 cycles worst case per instruction
	localparam int STEP_BOUND = MAX_STEPS * 27;
	localparam int WATCHDOG_NS = NUM_TESTS * STEP_BOUND * 4 + 2000;

	logic clk = 1'b0;
	logic reset;
	logic arclkena;
	logic arclkshift;
	logic ardout;
	logic drdin;
	logic drshift;
	logic [7:0] port0;
	logic [7:0] port1;
	logic [7:0] port2;

	// program under construction and the value expected at each marker
	logic [15:0] prog[$];
	logic [7:0] expect_q[$];
	int errors = 0;
	int tests_failed = 0;
	int test_start_errors;

	ravr_top i_ravr_top (
		.clk(clk),
		.reset(reset),
		.arclkena(arclkena),
		.arclkshift(arclkshift),
		.ardout(ardout),
		.drdin(drdin),
		.drshift(drshift),
		.port0(port0),
		.port1(port1),
		.port2(port2)
	);

	ufm_model i_ufm_model (
		.clk(clk),
		.arclkena(arclkena),
		.arclkshift(arclkshift),
		.ardout(ardout),
		.drshift(drshift),
		.drdin(drdin)
	);

	// 4 ns period
	always #2 clk = ~clk;

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// AVR style encodings
	function automatic logic [15:0] reg_word(input logic [2:0] cmd, input logic [2:0] d,
		input logic [2:0] s);
		return {2'b00, cmd[2], 1'b0, cmd[1:0], 3'b000, d, 1'b0, s};
	endfunction

	function automatic logic [15:0] imm_word(input logic [3:0] group, input logic [2:0] d,
		input logic [7:0] k);
		return {group, k[7:4], 1'b0, d, k[3:0]};
	endfunction

	function automatic logic [15:0] shift_word(input logic [2:0] d);
		return {7'b1001010, 2'b00, d, 4'b0110};
	endfunction

	// if_clear picks BRNE/BRCC, on_z picks Z over C
	function automatic logic [15:0] branch_word(input logic if_clear, input logic on_z,
		input logic [6:0] k);
		return {OP_BRANCH, 1'b0, if_clear, k, 2'b00, on_z};
	endfunction

	function automatic logic branch_taken(input logic if_clear, input logic on_z,
		input logic z, input logic c);
		logic flag;
		flag = on_z ? z : c;
		return if_clear ? ~flag : flag;
	endfunction

	function automatic void emit(input logic [15:0] w);
		prog.push_back(w);
	endfunction

	// expected data, then a numbered marker on the other port
	function automatic void add_step(input logic marker_on_port1, input logic [7:0] exp);
		expect_q.push_back(exp);
		emit(imm_word(OP_LDI, marker_on_port1 ? 3'd5 : 3'd4, 8'(expect_q.size())));
	endfunction

	// BRNE to itself, BREQ back to it, stuck for either Z
	function automatic void emit_halt();
		emit(branch_word(1'b1, 1'b1, 7'h7F));
		emit(branch_word(1'b0, 1'b1, 7'h7E));
	endfunction

	task automatic start_program();
		logic [8:0] addr;
		@(posedge clk);
		#1;
		reset = 1'b1;
		for (int i = 0; i < 512; i++)
		begin
			addr = 9'(i);
			// unused words hold a harmless LDI into the port2 slot
			if (i < prog.size())
				i_ufm_model.mem[addr] = prog[i];
			else
				i_ufm_model.mem[addr] = {OP_LDI, addr[7:4], addr[8], 3'd6, addr[3:0]};
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic check_value(input string test_name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %02h, actual %02h", test_name, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_marker(input string test_name, input logic on_port1,
		input logic [7:0] marker, output logic seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < STEP_BOUND)
		begin
			@(posedge clk);
			#1;
			seen = ((on_port1 ? port1 : port0) == marker);
			cycles++;
		end
		if (!seen)
		begin
			$display("%s: marker %0d never showed up on port%0d", test_name, marker, on_port1);
			errors++;
		end
	endtask

	task automatic check_steps(input string test_name, input logic data_on_port1);
		logic seen;
		logic [7:0] data;
		seen = 1'b1;
		for (int i = 0; i < expect_q.size() && seen; i++)
		begin
			wait_marker(test_name, ~data_on_port1, 8'(i + 1), seen);
			data = data_on_port1 ? port1 : port0;
			if (seen)
				check_value(test_name, expect_q[i], data);
		end
	endtask

	function automatic void begin_test();
		prog.delete();
		expect_q.delete();
		test_start_errors = errors;
	endfunction

	function automatic void end_test(input string test_name);
		if (errors == test_start_errors)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
		end
	endfunction

	task automatic test_reset_ldi();
		logic [7:0] v;
		begin_test();
		v = 8'($urandom());
		emit(imm_word(OP_LDI, 3'd4, v));
		add_step(1'b1, v);
		emit_halt();
		start_program();
		check_value("reset_ldi", 8'h00, port0);
		check_value("reset_ldi", 8'h00, port1);
		check_steps("reset_ldi", 1'b0);
		end_test("reset_ldi");
	endtask

	task automatic test_add_sub();
		logic [7:0] a;
		logic [7:0] b;
		begin_test();
		a = 8'($urandom());
		b = 8'($urandom());
		emit(imm_word(OP_LDI, 3'd0, a));
		emit(imm_word(OP_LDI, 3'd1, b));
		emit(reg_word(CMD_ADD, 3'd0, 3'd1));
		emit(reg_word(CMD_MOV, 3'd4, 3'd0));
		add_step(1'b1, 8'(a + b));
		emit(imm_word(OP_LDI, 3'd0, a));
		emit(reg_word(CMD_SUB, 3'd0, 3'd1));
		emit(reg_word(CMD_MOV, 3'd4, 3'd0));
		add_step(1'b1, 8'(a - b));
		emit_halt();
		start_program();
		check_steps("add_sub", 1'b0);
		end_test("add_sub");
	endtask

	// r0 = a, one op on r0, result to port1
	function automatic void logic_case(input logic [7:0] a, input logic [15:0] w,
		input logic [7:0] exp);
		emit(imm_word(OP_LDI, 3'd0, a));
		emit(w);
		emit(reg_word(CMD_MOV, 3'd5, 3'd0));
		add_step(1'b0, exp);
	endfunction

	task automatic test_logic_ops();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k;
		begin_test();
		a = 8'($urandom());
		b = 8'($urandom());
		k = 8'($urandom());
		emit(imm_word(OP_LDI, 3'd1, b));
		logic_case(a, reg_word(CMD_AND, 3'd0, 3'd1), a & b);
		logic_case(a, reg_word(CMD_OR, 3'd0, 3'd1), a | b);
		logic_case(a, reg_word(CMD_EOR, 3'd0, 3'd1), a ^ b);
		logic_case(a, imm_word(OP_ANDI, 3'd0, k), a & k);
		logic_case(a, imm_word(OP_ORI, 3'd0, k), a | k);
		logic_case(a, shift_word(3'd0), a >> 1);
		emit_halt();
		start_program();
		check_steps("logic_ops", 1'b1);
		end_test("logic_ops");
	endtask

	// compare x with y, branch over an LDI that marks port1
	function automatic void branch_case(input logic [7:0] x, input logic [7:0] y,
		input logic use_sub, input logic if_clear, input logic on_z);
		logic z;
		logic c;
		z = (x == y);
		c = (x < y);
		emit(imm_word(OP_LDI, 3'd0, x));
		emit(imm_word(OP_LDI, 3'd1, y));
		emit(imm_word(OP_LDI, 3'd5, 8'h55));
		emit(reg_word(use_sub ? CMD_SUB : CMD_CP, 3'd0, 3'd1));
		emit(branch_word(if_clear, on_z, 7'd1));
		emit(imm_word(OP_LDI, 3'd5, 8'hAA));
		add_step(1'b0, branch_taken(if_clear, on_z, z, c) ? 8'h55 : 8'hAA);
	endfunction

	task automatic test_branches();
		logic [7:0] a;
		logic [7:0] lo;
		logic [7:0] odd;
		begin_test();
		a = 8'($urandom());
		lo = a & 8'h7F;
		odd = a | 8'h01;
		branch_case(a, a, 1'b0, 1'b0, 1'b1);
		branch_case(a, a, 1'b0, 1'b1, 1'b1);
		branch_case(a, a ^ 8'h3C, 1'b0, 1'b0, 1'b1);
		branch_case(a, a ^ 8'h3C, 1'b0, 1'b1, 1'b1);
		// lo - hi borrows
		branch_case(lo, lo | 8'h80, 1'b1, 1'b0, 1'b0);
		branch_case(lo, lo | 8'h80, 1'b1, 1'b1, 1'b0);
		branch_case(lo | 8'h80, lo, 1'b1, 1'b1, 1'b0);
		// CPI against an equal immediate sets Z, r0 keeps its value
		emit(imm_word(OP_LDI, 3'd0, odd));
		emit(imm_word(OP_LDI, 3'd5, 8'h55));
		emit(imm_word(OP_CPI, 3'd0, odd));
		emit(branch_word(1'b0, 1'b1, 7'd1));
		emit(imm_word(OP_LDI, 3'd5, 8'hAA));
		add_step(1'b0, 8'h55);
		emit(reg_word(CMD_MOV, 3'd5, 3'd0));
		add_step(1'b0, odd);
		emit_halt();
		start_program();
		check_steps("branches", 1'b1);
		end_test("branches");
	endtask

	task automatic test_port2();
		logic [7:0] p;
		logic [7:0] k;
		logic [7:0] neg_k;
		begin_test();
		p = 8'($urandom());
		k = 8'($urandom());
		neg_k = 8'd0 - k;
		// no ADDI, subtract the negated value
		emit(reg_word(CMD_MOV, 3'd0, 3'd6));
		emit(imm_word(OP_SUBI, 3'd0, neg_k));
		emit(reg_word(CMD_MOV, 3'd4, 3'd0));
		add_step(1'b1, 8'(p + k));
		// write into the port2 slot is dropped
		emit(imm_word(OP_LDI, 3'd6, ~p));
		emit(reg_word(CMD_MOV, 3'd4, 3'd6));
		add_step(1'b1, p);
		emit(reg_word(CMD_MOV, 3'd4, 3'd0));
		add_step(1'b1, 8'(p + k));
		// r2 shares the low index bits of slot 6
		emit(reg_word(CMD_MOV, 3'd4, 3'd2));
		add_step(1'b1, 8'h00);
		emit_halt();
		@(posedge clk);
		#1;
		port2 = p;
		start_program();
		check_steps("port2", 1'b0);
		end_test("port2");
	endtask

	task automatic test_loop();
		logic [7:0] n;
		begin_test();
		n = 8'($urandom_range(8, 2));
		emit(imm_word(OP_LDI, 3'd0, n));
		emit(imm_word(OP_LDI, 3'd1, 8'd1));
		emit(imm_word(OP_LDI, 3'd2, 8'd0));
		// r2 counts passes, r0 counts down
		emit(reg_word(CMD_ADD, 3'd2, 3'd1));
		emit(reg_word(CMD_SUB, 3'd0, 3'd1));
		emit(branch_word(1'b1, 1'b1, 7'h7D));
		emit(reg_word(CMD_MOV, 3'd5, 3'd2));
		add_step(1'b0, n);
		emit(reg_word(CMD_MOV, 3'd5, 3'd0));
		add_step(1'b0, 8'd0);
		emit_halt();
		start_program();
		check_steps("loop", 1'b1);
		end_test("loop");
	endtask

	initial
	begin
		void'($urandom(32'hd6b2));
		reset = 1'b1;
		port2 = 8'h00;
		test_reset_ldi();
		test_add_sub();
		test_logic_ops();
		test_branches();
		test_port2();
		test_loop();
		$display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: compile.f
hw/ravr_pkg.sv
hw/ufm_sequencer.sv
hw/ravr_decode.sv
hw/ravr_alu.sv
hw/ravr_regs.sv
hw/ravr_top.sv
testbench/ufm_model.sv
testbench/ravr_chk.sv
testbench/ravr_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module ravr_tb -o ravr_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/ravr_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
